/* logic/fir_dsp_cfg.svh */
`ifndef FIR_DSP_CFG_SVH
`define FIR_DSP_CFG_SVH

////////////////////////////////////////
// Operand widths
////////////////////////////////////////

`define FIR_DSP_A_W 26
`define FIR_DSP_D_W 26
`define FIR_DSP_B_W 18
// P, C and PCIN share the accumulator width
`define FIR_DSP_P_W 48

////////////////////////////////////////
// Pipeline depths
////////////////////////////////////////

`define FIR_DSP_AREG 1
`define FIR_DSP_ADREG 1
`define FIR_DSP_MREG 1

// Detector compares only bits where the mask is one
`define FIR_DSP_PATTERN 48'h0000_0000_0000
`define FIR_DSP_MASK 48'hFFFF_FFFF_FFFF

`endif

/* logic/fir_dsp_pkg.sv */
`include "fir_dsp_cfg.svh"

package fir_dsp_pkg;

    ////////////////////////////////////////
    // Scalar datapath types
    ////////////////////////////////////////

    typedef logic signed [`FIR_DSP_A_W-1:0] fir_a_t;
    typedef logic signed [`FIR_DSP_D_W-1:0] fir_d_t;
    typedef logic signed [`FIR_DSP_B_W-1:0] fir_coef_t;
    // One guard bit so that D minus A cannot wrap
    typedef logic signed [`FIR_DSP_A_W:0] fir_preadd_t;
    // Full product of the preadder result and the coefficient
    typedef logic signed [`FIR_DSP_A_W+`FIR_DSP_B_W:0] fir_prod_t;
    typedef logic signed [`FIR_DSP_P_W-1:0] fir_acc_t;

    ////////////////////////////////////////
    // Grouped signals
    ////////////////////////////////////////

    // Per-sample operating mode
    typedef struct packed {
        logic use_d;
        logic sub_a;
        logic use_c;
        logic sub_c;     // only meaningful with use_c
        logic add_pcin;
    } fir_mode_t;

    typedef struct packed {
        fir_a_t   a;
        fir_d_t   d;
        fir_acc_t c;
        fir_acc_t pcin;
    } fir_sample_t;

    typedef struct packed {
        fir_coef_t coef;
        logic      load;
        logic      update;
    } fir_coef_load_t;

    typedef struct packed {
        fir_acc_t p;
        logic     pattern;
    } fir_result_t;

endpackage

/* logic/fir_pipe_delay.sv */
`timescale 1ns/1ps

module fir_pipe_delay #(
    parameter type         T     = logic,
    parameter int unsigned DEPTH = 1
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic en_i,
    input  T     data_i,
    output T     data_o
);

    generate
        if (DEPTH == 0) begin : g_bypass
            // No register stage requested
            assign data_o = data_i;
        end else begin : g_chain
            T stage_q [DEPTH];

            // Whole chain advances together, or holds
            always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stage_q[i] <= '0;
                    end
                end else if (en_i) begin
                    stage_q[0] <= data_i;
                    for (int i = 1; i < DEPTH; i++) begin
                        stage_q[i] <= stage_q[i-1];
                    end
                end
            end

            assign data_o = stage_q[DEPTH-1];
        end
    endgenerate

endmodule

/* logic/fir_dsp_ctrl.sv */
`timescale 1ns/1ps
`include "fir_dsp_cfg.svh"

module fir_dsp_ctrl (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  ce_i,
    input  logic                  in_valid_i,
    input  fir_dsp_pkg::fir_mode_t mode_i,
    output fir_dsp_pkg::fir_mode_t pre_mode_o,
    output fir_dsp_pkg::fir_mode_t alu_mode_o,
    output logic                  out_valid_o,
    output logic                  busy_o
);

    import fir_dsp_pkg::*;

    // Sample to product, then one more for the P register
    localparam int unsigned MULT_LAT = `FIR_DSP_AREG + `FIR_DSP_ADREG + `FIR_DSP_MREG;
    localparam int unsigned OUT_LAT  = MULT_LAT + 1;

    logic [OUT_LAT-1:0] valid_q;

    ////////////////////////////////////////
    // Mode alignment
    ////////////////////////////////////////

    // Mode meets A and D at the preadder
    fir_pipe_delay #(
        .T     (fir_mode_t),
        .DEPTH (`FIR_DSP_AREG)
    ) u_pre_mode_dly (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (ce_i),
        .data_i  (mode_i),
        .data_o  (pre_mode_o)
    );

    // Continue from the preadder stage to the product register
    fir_pipe_delay #(
        .T     (fir_mode_t),
        .DEPTH (`FIR_DSP_ADREG + `FIR_DSP_MREG)
    ) u_alu_mode_dly (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (ce_i),
        .data_i  (pre_mode_o),
        .data_o  (alu_mode_o)
    );

    ////////////////////////////////////////
    // Valid tracking
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (ce_i) begin
            valid_q <= {valid_q[OUT_LAT-2:0], in_valid_i};
        end
    end

    // Held cycles must not repeat the strobe
    assign out_valid_o = valid_q[OUT_LAT-1] & ce_i;
    assign busy_o      = |valid_q;

    a_out_valid_known: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(out_valid_o)
    ) else $error("out_valid_o is unknown");

endmodule

/* logic/fir_preadd_mult.sv */
`timescale 1ns/1ps
`include "fir_dsp_cfg.svh"

module fir_preadd_mult (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       ce_i,
    input  fir_dsp_pkg::fir_a_t         a_i,
    input  fir_dsp_pkg::fir_d_t         d_i,
    input  fir_dsp_pkg::fir_mode_t      mode_i,
    input  fir_dsp_pkg::fir_coef_load_t coef_i,
    output fir_dsp_pkg::fir_prod_t      product_o
);

    import fir_dsp_pkg::*;

    localparam int PRE_W = $bits(fir_preadd_t);

    fir_a_t                 a_q;
    fir_d_t                 d_q;
    logic signed [PRE_W:0]  a_wide;
    logic signed [PRE_W:0]  d_wide;
    logic signed [PRE_W:0]  pre_wide;
    fir_preadd_t            preadd_d;
    fir_preadd_t            preadd_q;
    fir_coef_t              coef_load_q;
    fir_coef_t              coef_work_q;
    fir_prod_t              mult_d;
    fir_prod_t              product_q;

    ////////////////////////////////////////
    // Input registers
    ////////////////////////////////////////

    fir_pipe_delay #(
        .T     (fir_a_t),
        .DEPTH (`FIR_DSP_AREG)
    ) u_a_dly (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (ce_i),
        .data_i  (a_i),
        .data_o  (a_q)
    );

    fir_pipe_delay #(
        .T     (fir_d_t),
        .DEPTH (`FIR_DSP_AREG)
    ) u_d_dly (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (ce_i),
        .data_i  (d_i),
        .data_o  (d_q)
    );

    ////////////////////////////////////////
    // Preadder
    ////////////////////////////////////////

    // One bit wider than the result so overflow is visible
    assign a_wide   = {{(PRE_W + 1 - `FIR_DSP_A_W){a_q[`FIR_DSP_A_W-1]}}, a_q};
    assign d_wide   = mode_i.use_d ? {{(PRE_W + 1 - `FIR_DSP_D_W){d_q[`FIR_DSP_D_W-1]}}, d_q}
                                   : '0;
    assign pre_wide = mode_i.sub_a ? d_wide - a_wide : d_wide + a_wide;
    assign preadd_d = pre_wide[PRE_W-1:0];

    // Load stage first, working stage on update
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            coef_load_q <= '0;
            coef_work_q <= '0;
        end else if (ce_i) begin
            if (coef_i.load) begin
                coef_load_q <= coef_i.coef;
            end
            if (coef_i.update) begin
                coef_work_q <= coef_load_q;   // old value when both strobes coincide
            end
        end
    end

    ////////////////////////////////////////
    // Preadder and product registers
    ////////////////////////////////////////

    assign mult_d = preadd_q * coef_work_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            preadd_q  <= '0;
            product_q <= '0;
        end else if (ce_i) begin
            preadd_q  <= preadd_d;
            product_q <= mult_d;
        end
    end

    assign product_o = product_q;

    a_preadd_range: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ce_i |-> (pre_wide[PRE_W] == pre_wide[PRE_W-1])
    ) else $error("Preadder result exceeds %0d bits", PRE_W);

endmodule

/* logic/fir_post_alu.sv */
`timescale 1ns/1ps
`include "fir_dsp_cfg.svh"

module fir_post_alu (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    ce_i,
    input  fir_dsp_pkg::fir_prod_t   product_i,
    input  fir_dsp_pkg::fir_acc_t    c_i,
    input  fir_dsp_pkg::fir_acc_t    pcin_i,
    input  fir_dsp_pkg::fir_mode_t   mode_i,
    output fir_dsp_pkg::fir_result_t result_o
);

    import fir_dsp_pkg::*;

    localparam int ACC_W  = $bits(fir_acc_t);
    localparam int PROD_W = $bits(fir_prod_t);

    fir_acc_t    c_q;
    fir_acc_t    pcin_q;
    fir_acc_t    prod_ext;
    fir_acc_t    w_mux;
    fir_acc_t    z_mux;
    logic        carry;
    fir_acc_t    p_d;
    logic        pattern_d;
    fir_result_t result_q;

    ////////////////////////////////////////
    // C and PCIN alignment
    ////////////////////////////////////////

    // Same depth as the sample path up to the product register
    fir_pipe_delay #(
        .T     (fir_acc_t),
        .DEPTH (`FIR_DSP_AREG + `FIR_DSP_ADREG + `FIR_DSP_MREG)
    ) u_c_dly (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (ce_i),
        .data_i  (c_i),
        .data_o  (c_q)
    );

    fir_pipe_delay #(
        .T     (fir_acc_t),
        .DEPTH (`FIR_DSP_AREG + `FIR_DSP_ADREG + `FIR_DSP_MREG)
    ) u_pcin_dly (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (ce_i),
        .data_i  (pcin_i),
        .data_o  (pcin_q)
    );

    ////////////////////////////////////////
    // Post-adder
    ////////////////////////////////////////

    assign prod_ext = {{(ACC_W - PROD_W){product_i[PROD_W-1]}}, product_i};

    // W slot is zero, C, or inverted C plus a carry
    always_comb begin
        w_mux = '0;
        carry = 1'b0;
        if (mode_i.use_c) begin
            if (mode_i.sub_c) begin
                w_mux = ~c_q;
                carry = 1'b1;
            end else begin
                w_mux = c_q;
            end
        end
    end

    assign z_mux = mode_i.add_pcin ? pcin_q : '0;

    // Sum wraps at the accumulator width
    assign p_d       = prod_ext + w_mux + z_mux + {{(ACC_W - 1){1'b0}}, carry};
    assign pattern_d = ((p_d ^ `FIR_DSP_PATTERN) & `FIR_DSP_MASK) == '0;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_q <= '0;
        end else if (ce_i) begin
            result_q.p       <= p_d;
            result_q.pattern <= pattern_d;
        end
    end

    assign result_o = result_q;

    a_sub_c_needs_c: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (ce_i && mode_i.sub_c) |-> mode_i.use_c
    ) else $warning("sub_c set without use_c, C is ignored");

endmodule

/* logic/fir_dsp_core.sv */
`timescale 1ns/1ps

module fir_dsp_core (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       ce_i,
    input  logic                       in_valid_i,
    input  fir_dsp_pkg::fir_sample_t    sample_i,
    input  fir_dsp_pkg::fir_mode_t      mode_i,
    input  fir_dsp_pkg::fir_coef_load_t coef_i,
    output fir_dsp_pkg::fir_result_t    result_o,
    output logic                       out_valid_o,
    output logic                       busy_o
);

    import fir_dsp_pkg::*;

    fir_mode_t pre_mode;
    fir_mode_t alu_mode;
    fir_prod_t product;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    fir_dsp_ctrl u_ctrl (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .ce_i        (ce_i),
        .in_valid_i  (in_valid_i),
        .mode_i      (mode_i),
        .pre_mode_o  (pre_mode),
        .alu_mode_o  (alu_mode),
        .out_valid_o (out_valid_o),
        .busy_o      (busy_o)
    );

    ////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////

    // Input, preadder and multiplier stages
    fir_preadd_mult u_preadd_mult (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .ce_i      (ce_i),
        .a_i       (sample_i.a),
        .d_i       (sample_i.d),
        .mode_i    (pre_mode),
        .coef_i    (coef_i),
        .product_o (product)
    );

    // C and PCIN enter raw and are aligned inside
    fir_post_alu u_post_alu (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .ce_i      (ce_i),
        .product_i (product),
        .c_i       (sample_i.c),
        .pcin_i    (sample_i.pcin),
        .mode_i    (alu_mode),
        .result_o  (result_o)
    );

endmodule

/* testbench/fir_dsp_core_tb.sv */
`timescale 1ns/1ps
`include "fir_dsp_cfg.svh"

module fir_dsp_core_tb;

    import fir_dsp_pkg::*;

    localparam int N_MAX   = 40;
    localparam int LATENCY = `FIR_DSP_AREG + `FIR_DSP_ADREG + `FIR_DSP_MREG + 1;
    // Coefficient action before a row uses load as bit 0 and update as bit 1
    localparam int CF_NONE = 0;
    localparam int CF_LOAD = 1;
    localparam int CF_UPD  = 2;
    localparam int CF_BOTH = 3;
    // Mode bits are use_d, sub_a, use_c, sub_c, add_pcin
    localparam fir_mode_t M_A     = 5'b00000;
    localparam fir_mode_t M_NEG_A = 5'b01000;
    localparam fir_mode_t M_DPA   = 5'b10000;
    localparam fir_mode_t M_DMA   = 5'b11000;

    logic           clk_i;
    logic           rst_n_i;
    logic           ce_i;
    logic           in_valid_i;
    fir_sample_t    sample_i;
    fir_mode_t      mode_i;
    fir_coef_load_t coef_i;
    fir_result_t    result_o;
    logic           out_valid_o;
    logic           busy_o;

    // Stimulus and expected values, one entry per row
    string       row_name    [N_MAX];
    fir_sample_t row_smp     [N_MAX];
    fir_mode_t   row_mode    [N_MAX];
    int          row_cf      [N_MAX];
    fir_coef_t   row_coef    [N_MAX];
    bit          row_burst   [N_MAX];
    int          row_hold    [N_MAX];
    fir_acc_t    row_exp_p   [N_MAX];
    logic        row_exp_pat [N_MAX];

    int          n_rows, cur_row, idx, stamp;
    int          err_cnt, done_cnt, en_cnt, cycle_cnt, max_cycles;
    logic        row_ok;
    logic [15:0] lfsr_q;
    int          sb_rows  [$];
    int          sb_stamp [$];

    fir_dsp_core UUT (.*);

    always #2 clk_i = ~clk_i;

    ////////////////////////////////////////
    // Reference model and table building
    ////////////////////////////////////////

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    task automatic take_bits(input int n, output logic [63:0] v);
        logic fb;
        begin
            v = '0;
            for (int i = 0; i < n; i++) begin
                fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
                lfsr_q = {lfsr_q[14:0], fb};
                v      = {v[62:0], fb};
            end
        end
    endtask

    function automatic fir_acc_t expected_p(fir_sample_t s, fir_mode_t m, fir_coef_t k);
        longint pre;
        longint sum;
        begin
            pre = m.use_d ? longint'($signed(s.d)) : 64'sd0;
            pre = m.sub_a ? pre - longint'($signed(s.a)) : pre + longint'($signed(s.a));
            sum = pre * longint'($signed(k));
            if (m.use_c) begin
                sum = m.sub_c ? sum - longint'($signed(s.c)) : sum + longint'($signed(s.c));
            end
            if (m.add_pcin) begin
                sum = sum + longint'($signed(s.pcin));
            end
            // Keep the low 48 bits only
            return fir_acc_t'(sum);
        end
    endfunction

    // Detector hit when every selected bit equals the pattern bit
    function automatic logic masked_match(fir_acc_t p);
        logic [`FIR_DSP_P_W-1:0] pat;
        logic [`FIR_DSP_P_W-1:0] msk;
        logic                    hit;
        begin
            pat = `FIR_DSP_PATTERN;
            msk = `FIR_DSP_MASK;
            hit = 1'b1;
            for (int b = 0; b < `FIR_DSP_P_W; b++) begin
                if (msk[b] && (p[b] !== pat[b])) begin
                    hit = 1'b0;
                end
            end
            return hit;
        end
    endfunction

    task automatic add_row(input string nm, input fir_a_t a, input fir_d_t d,
                           input fir_acc_t c, input fir_acc_t pcin, input fir_mode_t m,
                           input int cf, input fir_coef_t k, input bit burst, input int hold);
        begin
            row_name[n_rows]  = nm;
            row_smp[n_rows]   = '{a: a, d: d, c: c, pcin: pcin};
            row_mode[n_rows]  = m;
            row_cf[n_rows]    = cf;
            row_coef[n_rows]  = k;
            row_burst[n_rows] = burst;
            row_hold[n_rows]  = hold;
            n_rows++;
        end
    endtask

    task automatic add_random_rows(input int cnt);
        logic [63:0] ra, rd, rc, rp, rm, rk;
        fir_mode_t   m;
        begin
            for (int i = 0; i < cnt; i++) begin
                take_bits(26, ra);
                take_bits(26, rd);
                take_bits(48, rc);
                take_bits(48, rp);
                take_bits(5, rm);
                take_bits(18, rk);
                m       = rm[4:0];
                m.sub_c = m.sub_c & m.use_c;
                add_row($sformatf("lfsr_%0d", i), ra[25:0], rd[25:0], rc[47:0], rp[47:0], m,
                        (i == 0) ? CF_BOTH : CF_NONE, rk[17:0], (i % 3) != 0, 0);
            end
        end
    endtask

    // Walk the table with a coefficient model, then size the timeout
    task automatic fill_expected();
        fir_coef_t load_m;
        fir_coef_t work_m;
        int        budget;
        begin
            load_m = '0;
            work_m = '0;
            budget = 3 + 10;
            for (int i = 0; i < n_rows; i++) begin
                if (row_cf[i][0]) load_m = row_coef[i];
                if (row_cf[i][1]) work_m = load_m;
                row_exp_p[i]   = expected_p(row_smp[i], row_mode[i], work_m);
                row_exp_pat[i] = masked_match(row_exp_p[i]);
                budget += 9 + row_hold[i];
            end
            max_cycles = 4 * budget;
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic drive_idle(input logic ce, input fir_coef_load_t cf);
        begin
            @(posedge clk_i);
            ce_i       <= ce;
            in_valid_i <= 1'b0;
            coef_i     <= cf;
        end
    endtask

    // Busy low at a falling edge means every result was already seen
    task automatic wait_drained();
        begin
            drive_idle(1'b1, '0);
            @(negedge clk_i);
            while (busy_o) begin
                drive_idle(1'b1, '0);
                @(negedge clk_i);
            end
        end
    endtask

    task automatic apply_row(input int i);
        begin
            if (!row_burst[i] || row_cf[i] != CF_NONE) wait_drained();
            if (row_cf[i][0]) drive_idle(1'b1, '{coef: row_coef[i], load: 1'b1, update: 1'b0});
            if (row_cf[i][1]) drive_idle(1'b1, '{coef: '0, load: 1'b0, update: 1'b1});
            for (int h = 0; h < row_hold[i]; h++) begin
                drive_idle(1'b0, '0);
            end
            @(posedge clk_i);
            ce_i       <= 1'b1;
            in_valid_i <= 1'b1;
            sample_i   <= row_smp[i];
            mode_i     <= row_mode[i];
            coef_i     <= '0;
            cur_row    <= i;
        end
    endtask

    ////////////////////////////////////////
    // Scoreboard and watchdog
    ////////////////////////////////////////

    always @(negedge clk_i) begin
        if (rst_n_i) begin
            assert (!(out_valid_o && !ce_i)) else begin
                $display("out_valid_o was high while ce_i was low");
                err_cnt++;
            end
            if (out_valid_o) begin
                assert (sb_rows.size() != 0) else begin
                    $display("out_valid_o was high with no sample outstanding");
                    err_cnt++;
                end
                if (sb_rows.size() != 0) begin
                    idx    = sb_rows.pop_front();
                    stamp  = sb_stamp.pop_front();
                    row_ok = result_o.p == row_exp_p[idx] &&
                             result_o.pattern == row_exp_pat[idx];
                    done_cnt++;
                    assert (row_ok) else begin
                        $display("mismatch %s expected p=%0d pattern=%0b actual p=%0d pattern=%0b",
                                 row_name[idx], row_exp_p[idx], row_exp_pat[idx],
                                 result_o.p, result_o.pattern);
                        err_cnt++;
                    end
                    assert (en_cnt - stamp == LATENCY) else begin
                        $display("%s arrived after %0d enabled cycles instead of %0d",
                                 row_name[idx], en_cnt - stamp, LATENCY);
                        err_cnt++;
                    end
                    if (row_ok) $display("ok %s p=%0d", row_name[idx], result_o.p);
                end
            end
            if (in_valid_i && ce_i) begin
                sb_rows.push_back(cur_row);
                sb_stamp.push_back(en_cnt);
            end
            if (ce_i) en_cnt++;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (max_cycles != 0 && cycle_cnt >= max_cycles) begin
            $display("timeout after %0d cycles, results still outstanding", cycle_cnt);
            $display("Finished with errors");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        clk_i      = 1'b0;
        rst_n_i    = 1'b0;
        ce_i       = 1'b0;
        in_valid_i = 1'b0;
        sample_i   = '0;
        mode_i     = '0;
        coef_i     = '0;
        lfsr_q     = 16'd76;
        n_rows     = 0;
        cur_row    = 0;
        err_cnt    = 0;
        done_cnt   = 0;
        en_cnt     = 0;
        cycle_cnt  = 0;
        max_cycles = 0;

        add_row("pre_a", 26'sd1000, 26'sd0, '0, '0, M_A, CF_BOTH, 18'sd3, 0, 0);
        add_row("pre_neg_a", 26'sd1000, 26'sd0, '0, '0, M_NEG_A, CF_NONE, '0, 0, 0);
        add_row("pre_d_plus_a", 26'sd1000, 26'sd5000, '0, '0, M_DPA, CF_NONE, '0, 0, 0);
        add_row("pre_d_minus_a", 26'sd1000, 26'sd5000, '0, '0, M_DMA, CF_NONE, '0, 0, 0);
        add_row("c_add", 26'sd1000, 26'sd0, 48'sd100000, '0, 5'b00100, CF_NONE, '0, 0, 0);
        add_row("c_sub", 26'sd1000, 26'sd0, 48'sd100000, '0, 5'b00110, CF_NONE, '0, 0, 0);
        add_row("pcin_add", 26'sd1000, 26'sd0, '0, 48'sh7FFF_FFFF_FFFF, 5'b00001,
                CF_NONE, '0, 0, 0);
        add_row("c_add_pcin", -26'sd7, 26'sd0, 48'sd55, 48'sd900, 5'b00101, CF_NONE, '0, 0, 0);
        add_row("c_sub_pcin", 26'sd9, 26'sd0, 48'sd55, -48'sd900, 5'b00111, CF_NONE, '0, 0, 0);
        add_row("most_negative", 26'sh200_0000, 26'sh200_0000, 48'sh8000_0000_0000,
                48'sh8000_0000_0000, 5'b10111, CF_BOTH, 18'sh2_0000, 0, 0);
        add_row("load_only", 26'sd1000, 26'sd0, '0, '0, M_A, CF_LOAD, 18'sd7, 0, 0);
        add_row("update_applies", 26'sd1000, 26'sd0, '0, '0, M_A, CF_UPD, '0, 0, 0);
        // Back to back with mixed modes and ce_i held low mid-burst
        add_row("burst_a", 26'sd11, 26'sd0, '0, '0, M_A, CF_NONE, '0, 0, 0);
        add_row("burst_d_minus_a", 26'sd3, 26'sd50, '0, '0, M_DMA, CF_NONE, '0, 1, 0);
        add_row("burst_c_add", 26'sd4, 26'sd0, 48'sd1, '0, 5'b00100, CF_NONE, '0, 1, 0);
        add_row("burst_ce_hold", 26'sd5, 26'sd6, '0, 48'sd2, 5'b10001, CF_NONE, '0, 1, 5);
        add_row("burst_neg_a", 26'sd8, 26'sd0, '0, '0, M_NEG_A, CF_NONE, '0, 1, 0);
        add_row("pat_d_eq_a", 26'sd12345, 26'sd12345, '0, '0, M_DMA, CF_NONE, '0, 0, 0);
        add_row("pat_c_cancel", 26'sd100, 26'sd0, 48'sd700, '0, 5'b00110, CF_NONE, '0, 0, 0);
        add_random_rows(8);
        fill_expected();

        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        ce_i    <= 1'b1;
        @(negedge clk_i);
        assert (!busy_o && !out_valid_o && result_o == '0) else begin
            $display("outputs were not cleared by reset");
            err_cnt++;
        end

        for (int i = 0; i < n_rows; i++) begin
            apply_row(i);
        end
        wait_drained();

        assert (done_cnt == n_rows) else begin
            $display("only %0d of %0d results arrived", done_cnt, n_rows);
            err_cnt++;
        end
        $display("tests run: %0d, results checked: %0d, errors: %0d", n_rows, done_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* fir_dsp_core.f */
+incdir+logic
logic/fir_dsp_pkg.sv
logic/fir_pipe_delay.sv
logic/fir_dsp_ctrl.sv
logic/fir_preadd_mult.sv
logic/fir_post_alu.sv
logic/fir_dsp_core.sv
testbench/fir_dsp_core_tb.sv

/* Bender.yml */
package:
  name: fir_dsp_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/fir_dsp_pkg.sv
      - logic/fir_pipe_delay.sv
      - logic/fir_dsp_ctrl.sv
      - logic/fir_preadd_mult.sv
      - logic/fir_post_alu.sv
      - logic/fir_dsp_core.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/fir_dsp_core_tb.sv
